// ==== design/flash_pkg.sv ====
package flash_pkg;

    // Flash geometry and bus burst size
    localparam int FLASH_ADDR_BITS = 24;
    localparam int BURST_BYTES = 8;
    localparam int BURST_CNT_BITS = $clog2(BURST_BYTES + 1);

    // Fast read, quad output
    localparam logic [7:0] CMD_QUAD_READ = 8'h6b;
    localparam int CMD_BITS = 8;

    // Serial clock counts per phase
    localparam int DUMMY_CLOCKS = 8;
    localparam int CLOCKS_PER_BYTE = 2;
    localparam int BIT_CNT_BITS = 5;

    // Reader phase encoding
    localparam logic [2:0] PHASE_IDLE = 3'd0;
    localparam logic [2:0] PHASE_CMD = 3'd1;
    localparam logic [2:0] PHASE_ADDR = 3'd2;
    localparam logic [2:0] PHASE_DUMMY = 3'd3;
    localparam logic [2:0] PHASE_DATA = 3'd4;

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    typedef struct packed {
        logic                       valid;
        logic [FLASH_ADDR_BITS-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic                       valid;
        logic [BURST_BYTES*8-1:0]   data;
        logic [1:0]                 resp;
    } axi_r_t;

    typedef struct packed {
        logic                       valid;
        logic [FLASH_ADDR_BITS-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic                       valid;
        logic [BURST_BYTES*8-1:0]   data;
        logic [BURST_BYTES-1:0]     strb;
    } axi_w_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } axi_b_t;

    // Manager drives r and b, slave drives ar, aw and w
    typedef struct packed {
        logic ar;
        logic r;
        logic aw;
        logic w;
        logic b;
    } axi_ready_t;

    typedef struct packed {
        logic       cs;
        logic       sclk;
        logic [3:0] io_out;
        logic [3:0] io_oe;
    } qspi_out_t;

endpackage

// ==== design/flash_reader.sv ====
module flash_reader
    import flash_pkg::*;
(
    input  logic                       bus,
    input  logic                       rst,
    input  logic [FLASH_ADDR_BITS-1:0] addr,
    input  logic                       start_read,
    input  logic                       keep_reading,
    input  logic [3:0]                 qspi_in,
    output logic                       data_ready,
    output logic [7:0]                 data_byte,
    output qspi_out_t                  qspi_out
);

    logic [2:0]                          phase;
    logic [BIT_CNT_BITS-1:0]             bit_cnt;
    logic [CMD_BITS+FLASH_ADDR_BITS-1:0] shift_reg;
    logic [3:0]                          hi_nibble;
    logic                                cs_q;
    logic                                sclk_q;
    logic [3:0]                          oe_q;
    logic                                sclk_rise;
    logic                                sclk_fall;

    // sclk is a plain toggle while a sequence runs
    assign sclk_rise = (phase != PHASE_IDLE) && !sclk_q;
    assign sclk_fall = (phase != PHASE_IDLE) && sclk_q;

    // Only io0 carries command and address, upper lines stay undriven
    assign qspi_out = '{
        cs:     cs_q,
        sclk:   sclk_q,
        io_out: {3'b000, shift_reg[CMD_BITS+FLASH_ADDR_BITS-1]},
        io_oe:  oe_q
    };

    always_ff @(posedge bus) begin
        if (rst) begin
            phase <= PHASE_IDLE;
            bit_cnt <= '0;
            cs_q <= 1'b1;
            sclk_q <= 1'b0;
            oe_q <= 4'b0000;
            data_ready <= 1'b0;
        end else begin
            data_ready <= 1'b0;
            if (phase == PHASE_IDLE) begin
                if (start_read) begin
                    phase <= PHASE_CMD;
                    bit_cnt <= BIT_CNT_BITS'(CMD_BITS - 1);
                    cs_q <= 1'b0;
                    oe_q <= 4'b0001;
                end
            end else if (sclk_rise) begin
                sclk_q <= 1'b1;
                // Second nibble completes the byte
                if (phase == PHASE_DATA && bit_cnt == '0) begin
                    data_ready <= 1'b1;
                end
            end else begin
                // Falling edge closes one serial clock
                sclk_q <= 1'b0;
                if (bit_cnt != '0) begin
                    bit_cnt <= bit_cnt - 1'b1;
                end else begin
                    case (phase)
                        PHASE_CMD: begin
                            phase <= PHASE_ADDR;
                            bit_cnt <= BIT_CNT_BITS'(FLASH_ADDR_BITS - 1);
                        end
                        PHASE_ADDR: begin
                            phase <= PHASE_DUMMY;
                            bit_cnt <= BIT_CNT_BITS'(DUMMY_CLOCKS - 1);
                            oe_q <= 4'b0000;
                        end
                        PHASE_DUMMY: begin
                            phase <= PHASE_DATA;
                            bit_cnt <= BIT_CNT_BITS'(CLOCKS_PER_BYTE - 1);
                        end
                        default: begin
                            // Byte boundary, stream on or release the flash
                            if (keep_reading) begin
                                bit_cnt <= BIT_CNT_BITS'(CLOCKS_PER_BYTE - 1);
                            end else begin
                                phase <= PHASE_IDLE;
                                cs_q <= 1'b1;
                            end
                        end
                    endcase
                end
            end
        end
    end

    // Serial payload: command plus address out, nibbles in
    always_ff @(posedge bus) begin
        if (phase == PHASE_IDLE && start_read) begin
            shift_reg <= {CMD_QUAD_READ, addr};
        end else if (sclk_fall) begin
            shift_reg <= {shift_reg[CMD_BITS+FLASH_ADDR_BITS-2:0], 1'b0};
        end

        if (sclk_rise && phase == PHASE_DATA) begin
            if (bit_cnt != '0) begin
                hi_nibble <= qspi_in;
            end else begin
                data_byte <= {hi_nibble, qspi_in};
            end
        end
    end

endmodule

// ==== design/flash_axi_slave.sv ====
module flash_axi_slave
    import flash_pkg::*;
(
    input  logic                       bus,
    input  logic                       rst,
    input  axi_ar_t                    ar,
    input  axi_aw_t                    aw,
    input  axi_w_t                     w,
    input  axi_ready_t                 mgr_ready,
    input  logic                       data_ready,
    input  logic [7:0]                 data_byte,
    output axi_r_t                     r,
    output axi_b_t                     b,
    output axi_ready_t                 sub_ready,
    output logic                       start_read,
    output logic [FLASH_ADDR_BITS-1:0] flash_addr,
    output logic                       keep_reading
);

    logic                      arready;
    logic                      rvalid;
    logic [BURST_BYTES*8-1:0]  read_data;
    logic [BURST_CNT_BITS-1:0] burst_cnt;
    logic                      wr_accept;
    logic                      bvalid;
    logic                      ar_fire;
    logic                      r_fire;
    logic                      b_fire;

    assign ar_fire = arready && ar.valid;
    assign r_fire = rvalid && mgr_ready.r;
    assign b_fire = bvalid && mgr_ready.b;

    // Reader runs straight off the accepted AR beat
    assign start_read = ar_fire;
    assign flash_addr = ar.addr;
    // More bytes wanted beyond the one now in flight
    assign keep_reading = burst_cnt > BURST_CNT_BITS'(1);

    assign r = '{valid: rvalid, data: read_data, resp: RESP_OKAY};
    assign b = '{valid: bvalid, resp: RESP_SLVERR};
    assign sub_ready = '{ar: arready, r: 1'b0, aw: wr_accept, w: wr_accept, b: 1'b0};

    always_ff @(posedge bus) begin
        if (rst) begin
            burst_cnt <= '0;
        end else if (ar_fire) begin
            burst_cnt <= BURST_CNT_BITS'(BURST_BYTES);
        end else if (data_ready) begin
            burst_cnt <= burst_cnt - 1'b1;
        end
    end

    // New byte enters at the top, first byte ends up lowest
    always_ff @(posedge bus) begin
        if (data_ready) begin
            read_data <= {data_byte, read_data[BURST_BYTES*8-1:8]};
        end
    end

    always_ff @(posedge bus) begin
        if (rst) begin
            arready <= 1'b1;
            rvalid <= 1'b0;
        end else begin
            if (ar_fire) begin
                arready <= 1'b0;
            end else if (r_fire) begin
                arready <= 1'b1;
            end

            if (r_fire) begin
                rvalid <= 1'b0;
            end else if (data_ready && burst_cnt == BURST_CNT_BITS'(1)) begin
                rvalid <= 1'b1;
            end
        end
    end

    // Writes are always refused, one at a time
    always_ff @(posedge bus) begin
        if (rst) begin
            wr_accept <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            wr_accept <= aw.valid && w.valid && !wr_accept && !bvalid;
            if (b_fire) begin
                bvalid <= 1'b0;
            end else if (wr_accept) begin
                bvalid <= 1'b1;
            end
        end
    end

endmodule

// ==== design/flash_subsystem.sv ====
module flash_subsystem
    import flash_pkg::*;
(
    input  logic       bus,
    input  logic       rst,
    input  axi_ar_t    ar,
    input  axi_aw_t    aw,
    input  axi_w_t     w,
    input  axi_ready_t mgr_ready,
    output axi_r_t     r,
    output axi_b_t     b,
    output axi_ready_t sub_ready,
    output qspi_out_t  qspi_out,
    input  logic [3:0] qspi_in
);

    logic                       start_read;
    logic                       keep_reading;
    logic [FLASH_ADDR_BITS-1:0] flash_addr;
    logic                       data_ready;
    logic [7:0]                 data_byte;

    flash_axi_slave slave0 (
        .bus          (bus),
        .rst          (rst),
        .ar           (ar),
        .aw           (aw),
        .w            (w),
        .mgr_ready    (mgr_ready),
        .data_ready   (data_ready),
        .data_byte    (data_byte),
        .r            (r),
        .b            (b),
        .sub_ready    (sub_ready),
        .start_read   (start_read),
        .flash_addr   (flash_addr),
        .keep_reading (keep_reading)
    );

    flash_reader reader0 (
        .bus          (bus),
        .rst          (rst),
        .addr         (flash_addr),
        .start_read   (start_read),
        .keep_reading (keep_reading),
        .qspi_in      (qspi_in),
        .data_ready   (data_ready),
        .data_byte    (data_byte),
        .qspi_out     (qspi_out)
    );

endmodule

// ==== bench/flash_model.sv ====
module flash_model
    import flash_pkg::*;
(
    input  qspi_out_t  qspi_out,
    output logic [3:0] qspi_in
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HEADER_CLOCKS = CMD_BITS + FLASH_ADDR_BITS;
    localparam int DATA_START = HEADER_CLOCKS + DUMMY_CLOCKS;

    int                         clocks = 0;
    int                         nibble_idx;
    logic [HEADER_CLOCKS-1:0]   header;
    logic [FLASH_ADDR_BITS-1:0] byte_addr;
    logic [7:0]                 data;
    logic [3:0]                 nibble = 4'h0;

    assign qspi_in = nibble;

    function automatic logic [7:0] pattern_byte(input logic [FLASH_ADDR_BITS-1:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    // Rising sclk counts serial clocks and shifts in command and address
    always @(posedge qspi_out.sclk or posedge qspi_out.cs) begin
        if (qspi_out.cs) begin
            clocks = 0;
        end else begin
            clocks = clocks + 1;
            if (clocks <= HEADER_CLOCKS)
                header = {header[HEADER_CLOCKS-2:0], qspi_out.io_out[0]};
        end
    end

    // Data changes on falling sclk, high nibble first
    always @(negedge qspi_out.sclk) begin
        if (!qspi_out.cs && clocks >= DATA_START) begin
            nibble_idx = clocks - DATA_START;
            byte_addr = header[FLASH_ADDR_BITS-1:0] + FLASH_ADDR_BITS'(nibble_idx / 2);
            data = pattern_byte(byte_addr);
            if (header[HEADER_CLOCKS-1 -: CMD_BITS] != CMD_QUAD_READ)
                nibble = 4'hf;  // unknown command leaves the lines pulled high
            else if (nibble_idx[0])
                nibble = data[3:0];
            else
                nibble = data[7:4];
        end
    end

endmodule

// ==== bench/flash_checker.sv ====
module flash_checker
    import flash_pkg::*;
(
    input logic                       bus,
    input logic                       rst,
    input axi_r_t                     r,
    input axi_ready_t                 mgr_ready,
    input axi_ready_t                 sub_ready,
    input logic                       data_ready,
    input logic                       start_read,
    input logic [FLASH_ADDR_BITS-1:0] flash_addr,
    input logic [BURST_CNT_BITS-1:0]  burst_cnt
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    rvalid_stable: assert property (@(posedge bus) disable iff (rst)
        r.valid && !mgr_ready.r |=> r.valid && $stable(r.data))
        else begin
            fail_count++;
            $error("rvalid dropped or rdata changed before rready");
        end

    no_byte_while_rvalid: assert property (@(posedge bus) disable iff (rst)
        data_ready |-> !r.valid)
        else begin
            fail_count++;
            $error("flash byte arrived while a read response was waiting");
        end

    // A read is open from AR acceptance until the R transfer
    single_read_open: assert property (@(posedge bus) disable iff (rst)
        (r.valid || burst_cnt != '0) |-> !sub_ready.ar)
        else begin
            fail_count++;
            $error("arready high while a read is outstanding");
        end

    start_addr_known: assert property (@(posedge bus) disable iff (rst)
        start_read |-> !$isunknown(flash_addr))
        else begin
            fail_count++;
            $error("start_read issued with an unknown flash address");
        end

endmodule

bind flash_axi_slave flash_checker chk0 (
    .bus        (bus),
    .rst        (rst),
    .r          (r),
    .mgr_ready  (mgr_ready),
    .sub_ready  (sub_ready),
    .data_ready (data_ready),
    .start_read (start_read),
    .flash_addr (flash_addr),
    .burst_cnt  (burst_cnt)
);

// ==== bench/flash_monitor.sv ====
module flash_monitor
    import flash_pkg::*;
(
    input  logic       bus,
    input  logic       rst,
    input  axi_ar_t    ar,
    input  axi_aw_t    aw,
    input  axi_ready_t mgr_ready,
    input  axi_r_t     r,
    input  axi_b_t     b,
    input  axi_ready_t sub_ready,
    input  qspi_out_t  qspi_out,
    input  logic [1:0] expect_resp,
    output int         test_count,
    output int         error_count
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [FLASH_ADDR_BITS-1:0] read_q[$];
    logic [FLASH_ADDR_BITS-1:0] write_q[$];
    logic [FLASH_ADDR_BITS-1:0] addr;
    logic [BURST_BYTES*8-1:0]   exp_word;
    logic [BURST_BYTES*8-1:0]   held_data;
    logic                       r_held = 1'b0;
    logic                       b_held = 1'b0;
    logic                       reset_seen = 1'b0;
    int                         tests = 0;
    int                         errors = 0;
    int                         errors_before = 0;

    assign test_count = tests;
    assign error_count = errors;

    // Byte k of the word comes from flash address base+k, wrapping at 2^24
    function automatic logic [BURST_BYTES*8-1:0] expected_word(
        input logic [FLASH_ADDR_BITS-1:0] base
    );
        logic [BURST_BYTES*8-1:0]   word;
        logic [FLASH_ADDR_BITS-1:0] a;
        int                         k;
        word = '0;
        for (k = 0; k < BURST_BYTES; k++) begin
            a = base + FLASH_ADDR_BITS'(k);
            word[k*8 +: 8] = a[7:0] ^ a[15:8] ^ 8'h5a;
        end
        return word;
    endfunction

    task automatic mismatch(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
        errors++;
        $display("CHECK FAILED: %s expected 0x%0h got 0x%0h", name, expected, actual);
    endtask

    task automatic finish_test(input string kind, input logic [FLASH_ADDR_BITS-1:0] at);
        tests++;
        $display("test %0d %s 0x%06h: %s", tests, kind, at,
                 (errors == errors_before) ? "ok" : "error");
        errors_before = errors;
    endtask

    // Inputs settle 1 ns after the rising edge, so the falling edge sees stable values
    always @(negedge bus) begin
        if (!rst && !reset_seen) begin
            reset_seen = 1'b1;
            if (sub_ready.ar !== 1'b1) mismatch("arready", 64'(1'b1), 64'(sub_ready.ar));
            if (sub_ready.aw !== 1'b0) mismatch("awready", 64'(1'b0), 64'(sub_ready.aw));
            if (sub_ready.w !== 1'b0) mismatch("wready", 64'(1'b0), 64'(sub_ready.w));
            if (r.valid !== 1'b0) mismatch("rvalid", 64'(1'b0), 64'(r.valid));
            if (b.valid !== 1'b0) mismatch("bvalid", 64'(1'b0), 64'(b.valid));
            if (qspi_out.cs !== 1'b1) mismatch("qspi_out.cs", 64'(1'b1), 64'(qspi_out.cs));
            if (qspi_out.sclk !== 1'b0)
                mismatch("qspi_out.sclk", 64'(1'b0), 64'(qspi_out.sclk));
            if (qspi_out.io_oe !== 4'h0)
                mismatch("qspi_out.io_oe", 64'(4'h0), 64'(qspi_out.io_oe));
            finish_test("reset", '0);
        end else if (!rst) begin
            if (ar.valid && sub_ready.ar) read_q.push_back(ar.addr);
            if (aw.valid && sub_ready.aw) write_q.push_back(aw.addr);
            // awready and wready always pulse together
            if (sub_ready.w !== sub_ready.aw)
                mismatch("wready", 64'(sub_ready.aw), 64'(sub_ready.w));
            if (r_held && r.valid !== 1'b1) mismatch("rvalid (held)", 64'(1'b1), 64'(r.valid));
            if (r_held && r.data !== held_data) mismatch("r.data (held)", held_data, r.data);
            // Burst is over once the word is valid
            if (r.valid) begin
                if (qspi_out.cs !== 1'b1)
                    mismatch("qspi_out.cs", 64'(1'b1), 64'(qspi_out.cs));
                if (qspi_out.sclk !== 1'b0)
                    mismatch("qspi_out.sclk", 64'(1'b0), 64'(qspi_out.sclk));
                if (qspi_out.io_oe !== 4'h0)
                    mismatch("qspi_out.io_oe", 64'(4'h0), 64'(qspi_out.io_oe));
            end
            if (b_held && !b.valid) mismatch("bvalid (held)", 64'(1'b1), 64'(b.valid));
            if (r.valid && mgr_ready.r) begin
                if (read_q.size() == 0) begin
                    errors++;
                    $display("A read response arrived with no read request pending");
                end else begin
                    addr = read_q.pop_front();
                    exp_word = expected_word(addr);
                    if (r.data !== exp_word) mismatch("r.data", exp_word, r.data);
                    if (r.resp !== expect_resp) mismatch("r.resp", 64'(expect_resp), 64'(r.resp));
                    finish_test("read", addr);
                end
            end
            if (b.valid && mgr_ready.b) begin
                if (write_q.size() == 0) begin
                    errors++;
                    $display("A write response arrived with no write request pending");
                end else begin
                    addr = write_q.pop_front();
                    if (b.resp !== expect_resp) mismatch("b.resp", 64'(expect_resp), 64'(b.resp));
                    finish_test("write", addr);
                end
            end
            r_held = r.valid && !mgr_ready.r;
            b_held = b.valid && !mgr_ready.b;
            held_data = r.data;
        end
    end

endmodule

// ==== bench/flash_tb.sv ====
module flash_tb
    import flash_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TESTS = 10;
    localparam int CYCLES_PER_TEST = 150;
    localparam int PERIOD_NS = 4;

    typedef struct packed {
        logic                       is_write;
        logic [FLASH_ADDR_BITS-1:0] addr;
        logic [3:0]                 hold;
        logic [1:0]                 resp;
    } stim_t;

    logic        bus;
    logic        rst;
    axi_ar_t     ar;
    axi_aw_t     aw;
    axi_w_t      w;
    axi_ready_t  mgr_ready;
    axi_r_t      r;
    axi_b_t      b;
    axi_ready_t  sub_ready;
    qspi_out_t   qspi_out;
    logic [3:0]  qspi_in;
    logic [1:0]  expect_resp;
    int          test_count;
    int          error_count;
    stim_t       stim [NUM_TESTS];
    int          seed;
    logic [31:0] rand_word;
    int          idx;

    flash_subsystem dut0 (
        .bus       (bus),
        .rst       (rst),
        .ar        (ar),
        .aw        (aw),
        .w         (w),
        .mgr_ready (mgr_ready),
        .r         (r),
        .b         (b),
        .sub_ready (sub_ready),
        .qspi_out  (qspi_out),
        .qspi_in   (qspi_in)
    );

    flash_model flash0 (
        .qspi_out (qspi_out),
        .qspi_in  (qspi_in)
    );

    flash_monitor mon0 (
        .bus         (bus),
        .rst         (rst),
        .ar          (ar),
        .aw          (aw),
        .mgr_ready   (mgr_ready),
        .r           (r),
        .b           (b),
        .sub_ready   (sub_ready),
        .qspi_out    (qspi_out),
        .expect_resp (expect_resp),
        .test_count  (test_count),
        .error_count (error_count)
    );

    initial begin
        bus = 1'b0;
        forever #(PERIOD_NS / 2) bus = ~bus;
    end

    // A burst needs about 115 cycles, so 150 per table entry leaves room
    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * PERIOD_NS);
        $display("Timeout after %0d cycles with the table still running",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("Test failed");
        $finish;
    end

    task automatic issue_read(input logic [FLASH_ADDR_BITS-1:0] addr, input logic [3:0] hold);
        ar.valid = 1'b1;
        ar.addr = addr;
        @(negedge bus);
        while (!sub_ready.ar) @(negedge bus);
        @(posedge bus);
        #1;
        ar.valid = 1'b0;
        // Keep rready low for a few cycles once the word is valid
        if (hold != 4'd0) begin
            @(negedge bus);
            while (!r.valid) @(negedge bus);
            repeat (hold) @(posedge bus);
            #1;
        end
        mgr_ready.r = 1'b1;
        @(negedge bus);
        while (!r.valid) @(negedge bus);
        @(posedge bus);
        #1;
        mgr_ready.r = 1'b0;
    endtask

    task automatic issue_write(input logic [FLASH_ADDR_BITS-1:0] addr, input logic [3:0] hold);
        aw.valid = 1'b1;
        aw.addr = addr;
        w.valid = 1'b1;
        w.data = 64'h0123_4567_89ab_cdef;
        w.strb = 8'hff;
        @(negedge bus);
        while (!(sub_ready.aw && sub_ready.w)) @(negedge bus);
        @(posedge bus);
        #1;
        aw.valid = 1'b0;
        w.valid = 1'b0;
        if (hold != 4'd0) begin
            @(negedge bus);
            while (!b.valid) @(negedge bus);
            repeat (hold) @(posedge bus);
            #1;
        end
        mgr_ready.b = 1'b1;
        @(negedge bus);
        while (!b.valid) @(negedge bus);
        @(posedge bus);
        #1;
        mgr_ready.b = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        ar = '0;
        aw = '0;
        w = '0;
        mgr_ready = '0;
        expect_resp = RESP_OKAY;
        seed = 32'ha7e66a12;
        // Aligned, unaligned, wrapping at the top, then R back-pressure
        stim[0] = '{is_write: 1'b0, addr: 24'h000000, hold: 4'd0, resp: RESP_OKAY};
        stim[1] = '{is_write: 1'b0, addr: 24'h000013, hold: 4'd0, resp: RESP_OKAY};
        stim[2] = '{is_write: 1'b0, addr: 24'hfffffc, hold: 4'd0, resp: RESP_OKAY};
        stim[3] = '{is_write: 1'b0, addr: 24'h123456, hold: 4'd6, resp: RESP_OKAY};
        // Rejected writes, the second one with B back-pressure
        stim[4] = '{is_write: 1'b1, addr: 24'h000040, hold: 4'd0, resp: RESP_SLVERR};
        stim[5] = '{is_write: 1'b0, addr: 24'h000040, hold: 4'd0, resp: RESP_OKAY};
        stim[6] = '{is_write: 1'b1, addr: 24'h000080, hold: 4'd5, resp: RESP_SLVERR};
        for (idx = 7; idx < NUM_TESTS; idx++) begin
            rand_word = $random(seed);
            stim[idx] = '{is_write: 1'b0, addr: rand_word[FLASH_ADDR_BITS-1:0],
                          hold: 4'(idx - 7), resp: RESP_OKAY};
        end

        repeat (3) @(posedge bus);
        #1;
        rst = 1'b0;
        @(posedge bus);
        #1;
        // Each entry starts as soon as the previous transfer completes
        for (idx = 0; idx < NUM_TESTS; idx++) begin
            expect_resp = stim[idx].resp;
            if (stim[idx].is_write)
                issue_write(stim[idx].addr, stim[idx].hold);
            else
                issue_read(stim[idx].addr, stim[idx].hold);
        end
        @(negedge bus);

        $display("%0d tests run, %0d errors, %0d assertion failures",
                 test_count, error_count, dut0.slave0.chk0.fail_count);
        if (error_count == 0 && dut0.slave0.chk0.fail_count == 0 &&
            test_count == NUM_TESTS + 1) begin
            $display("Test completed successfully");
        end else begin
            if (test_count != NUM_TESTS + 1)
                $display("Only %0d of %0d tests finished", test_count, NUM_TESTS + 1);
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
design/flash_pkg.sv
design/flash_reader.sv
design/flash_axi_slave.sv
design/flash_subsystem.sv
bench/flash_model.sv
bench/flash_checker.sv
bench/flash_monitor.sv
bench/flash_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= flash_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not from the simulator exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
